// File: elevator_bank.f
+incdir+common
common/elev_pkg.sv
common/car_link_if.sv
hw/bank_cfg.sv
hw/hall_dispatch/hall_dispatch.sv
hw/car/car_ctrl.sv
hw/elevator_bank.sv
tests/tb_elevator_bank.sv

// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing
TOP       := tb_elevator_bank
FILELIST  := elevator_bank.f
OBJ_DIR   := obj_dir

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(OBJ_DIR)/V$(TOP)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

// File: tests/tb_elevator_bank.sv
// Self-checking testbench for the two-car elevator bank.
// Hall lamps clear when a call is handed to a car, not when its door opens.
`timescale 1ns/1ns
`default_nettype none

module tb_elevator_bank;

    localparam int max_cycles = 20000;

    logic                  clk;
    logic                  rst_n;
    logic                  cfg_req;
    elev_pkg::cfg_sel_t    cfg_sel;
    elev_pkg::cycles_t     cfg_data;
    logic                  cfg_ack;
    elev_pkg::floor_mask_t hall_up;
    elev_pkg::floor_mask_t hall_down;
    elev_pkg::floor_mask_t up_lit;
    elev_pkg::floor_mask_t down_lit;
    elev_pkg::floor_mask_t car0_call;
    elev_pkg::floor_mask_t car1_call;
    elev_pkg::floor_t      car0_floor;
    elev_pkg::floor_t      car1_floor;
    logic                  car0_door_open;
    logic                  car1_door_open;
    elev_pkg::floor_mask_t car0_lit;
    elev_pkg::floor_mask_t car1_lit;

    // Scoreboard state.
    string       cur_test;
    int          errors;
    int          tests_run;
    int          tests_failed;
    int          test_err_start;
    int          cycles;
    logic [31:0] rnd;

    // Monitor history from the previous sample.
    logic                  mon_on;
    logic                  mon_primed;
    elev_pkg::floor_t      p_f0;
    elev_pkg::floor_t      p_f1;
    logic                  p_do0;
    logic                  p_do1;
    elev_pkg::floor_mask_t p_up;
    elev_pkg::floor_mask_t p_down;
    elev_pkg::floor_mask_t p_hup;
    elev_pkg::floor_mask_t p_hdown;
    elev_pkg::floor_mask_t p_lit0;
    elev_pkg::floor_mask_t p_lit1;
    elev_pkg::floor_mask_t p_call0;
    elev_pkg::floor_mask_t p_call1;

    elevator_bank u_elevator_bank (
        .clk           (clk),
        .rst_n         (rst_n),
        .cfg_req       (cfg_req),
        .cfg_sel       (cfg_sel),
        .cfg_data      (cfg_data),
        .cfg_ack       (cfg_ack),
        .hall_up       (hall_up),
        .hall_down     (hall_down),
        .up_lit        (up_lit),
        .down_lit      (down_lit),
        .car0_call     (car0_call),
        .car1_call     (car1_call),
        .car0_floor    (car0_floor),
        .car1_floor    (car1_floor),
        .car0_door_open(car0_door_open),
        .car1_door_open(car1_door_open),
        .car0_lit      (car0_lit),
        .car1_lit      (car1_lit)
    );

    //************************************************************
    // Clock and cycle limit.
    //************************************************************

    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // Worst case is a few hundred trips at 4 travel plus 3 x 2 door cycles.
    initial begin
        cycles = 0;
        forever begin
            @(posedge clk);
            cycles++;
            if (cycles >= max_cycles) begin
                $display("Timeout: the run did not finish within %0d cycles.", max_cycles);
                $display("tests failed");
                $finish;
            end
        end
    end

    //************************************************************
    // Reference functions.
    //************************************************************

    // A lamp can only show what was lit or pressed one cycle before.
    function automatic elev_pkg::floor_mask_t lamp_ref(elev_pkg::floor_mask_t prev,
                                                       elev_pkg::floor_mask_t press);
        return prev | press;
    endfunction

    // The floor may step by one only when the door was shut.
    function automatic logic step_ok(elev_pkg::floor_t prev, elev_pkg::floor_t cur,
                                     logic was_open);
        int diff;
        diff = int'(cur) - int'(prev);
        if (was_open) begin
            return diff == 0;
        end
        return (diff >= -1) && (diff <= 1);
    endfunction

    function automatic elev_pkg::floor_mask_t onehot(elev_pkg::floor_t fl);
        return elev_pkg::floor_mask_t'(1) << fl;
    endfunction

    // Fixed-seed LCG for the stress test.
    function automatic logic [31:0] lcg_next(logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    //************************************************************
    // Compare tasks.
    //************************************************************

    task automatic check_floor(string what, elev_pkg::floor_t exp, elev_pkg::floor_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    task automatic check_mask(string what, elev_pkg::floor_mask_t exp,
                              elev_pkg::floor_mask_t act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_bit(string what, logic exp, logic act);
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s expected %b actual %b", cur_test, what, exp, act);
        end
    endtask

    task automatic check_count(string what, int exp, int act);
        if (act != exp) begin
            errors++;
            $display("ERR %s %s expected %0d actual %0d", cur_test, what, exp, act);
        end
    endtask

    //************************************************************
    // Invariant monitor on the falling edge.
    //************************************************************

    always @(negedge clk) begin
        if (mon_on) begin
            if (mon_primed) begin
                check_bit("car0 step", 1'b1, step_ok(p_f0, car0_floor, p_do0));
                check_bit("car1 step", 1'b1, step_ok(p_f1, car1_floor, p_do1));
                // A hall lamp only lights from a press.
                check_mask("up lamp set", '0, up_lit & ~lamp_ref(p_up, p_hup));
                check_mask("down lamp set", '0, down_lit & ~lamp_ref(p_down, p_hdown));
                // A hall lamp goes out only when a car takes the call.
                check_mask("up lamp clear", '0,
                           lamp_ref(p_up, p_hup) & ~up_lit & ~(car0_lit | car1_lit));
                check_mask("down lamp clear", '0,
                           lamp_ref(p_down, p_hdown) & ~down_lit & ~(car0_lit | car1_lit));
                // Car buttons come from the car's own calls or from hall handover.
                check_mask("car0 lamp set", '0, car0_lit
                           & ~lamp_ref(p_lit0, p_call0 | p_up | p_down | p_hup | p_hdown));
                check_mask("car1 lamp set", '0, car1_lit
                           & ~lamp_ref(p_lit1, p_call1 | p_up | p_down | p_hup | p_hdown));
                // Car buttons clear only at the floor the car stands on.
                check_mask("car0 lamp clear", '0, p_lit0 & ~car0_lit & ~onehot(p_f0));
                check_mask("car1 lamp clear", '0, p_lit1 & ~car1_lit & ~onehot(p_f1));
            end
            p_f0       = car0_floor;
            p_f1       = car1_floor;
            p_do0      = car0_door_open;
            p_do1      = car1_door_open;
            p_up       = up_lit;
            p_down     = down_lit;
            p_hup      = hall_up;
            p_hdown    = hall_down;
            p_lit0     = car0_lit;
            p_lit1     = car1_lit;
            p_call0    = car0_call;
            p_call1    = car1_call;
            mon_primed = 1'b1;
        end
    end

    //************************************************************
    // Stimulus helpers.
    //************************************************************

    // Inputs change 1 ns after the rising edge.
    task automatic drive_slot();
        @(posedge clk);
        #1;
    endtask

    task automatic begin_test(string name);
        cur_test       = name;
        test_err_start = errors;
        tests_run++;
    endtask

    task automatic end_test();
        if (errors != test_err_start) begin
            tests_failed++;
            $display("%s: FAIL, %0d errors", cur_test, errors - test_err_start);
        end else begin
            $display("%s: ok", cur_test);
        end
    endtask

    // Four-phase write into the timing registers.
    task automatic cfg_write(elev_pkg::cfg_sel_t sel, elev_pkg::cycles_t data);
        drive_slot();
        cfg_sel  = sel;
        cfg_data = data;
        cfg_req  = 1'b1;
        @(negedge clk);
        while (!cfg_ack) begin
            @(negedge clk);
        end
        drive_slot();
        cfg_req = 1'b0;
        @(negedge clk);
        check_bit("ack held until req seen low", 1'b1, cfg_ack);
        while (cfg_ack) begin
            @(negedge clk);
        end
    endtask

    task automatic press_car(int car, elev_pkg::floor_t fl);
        drive_slot();
        if (car == 0) begin
            car0_call = onehot(fl);
        end else begin
            car1_call = onehot(fl);
        end
        drive_slot();
        car0_call = '0;
        car1_call = '0;
    endtask

    // Wait for a car standing at a floor with its door open.
    task automatic wait_served(int car, elev_pkg::floor_t fl);
        @(negedge clk);
        while (car == 0 ? !(car0_floor == fl && car0_door_open)
                        : !(car1_floor == fl && car1_door_open)) begin
            @(negedge clk);
        end
    endtask

    // Wait until no lamp is lit and both doors are shut.
    task automatic wait_idle();
        @(negedge clk);
        while ((up_lit | down_lit | car0_lit | car1_lit) != '0
               || car0_door_open || car1_door_open) begin
            @(negedge clk);
        end
    endtask

    //************************************************************
    // Test sequence.
    //************************************************************

    initial begin
        int n;
        rst_n        = 1'b0;
        cfg_req      = 1'b0;
        cfg_sel      = elev_pkg::CFG_TRAVEL;
        cfg_data     = '0;
        hall_up      = '0;
        hall_down    = '0;
        car0_call    = '0;
        car1_call    = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        mon_on       = 1'b0;
        mon_primed   = 1'b0;
        rnd          = 32'd55673;
        cur_test     = "reset";
        repeat (2) @(posedge clk);
        #1 rst_n = 1'b1;

        // State right after reset.
        begin_test("reset");
        @(negedge clk);
        check_floor("car0 floor", '0, car0_floor);
        check_floor("car1 floor", '0, car1_floor);
        check_bit("car0 door", 1'b0, car0_door_open);
        check_bit("car1 door", 1'b0, car1_door_open);
        check_mask("up lamps", '0, up_lit);
        check_mask("down lamps", '0, down_lit);
        check_mask("car0 lamps", '0, car0_lit);
        check_mask("car1 lamps", '0, car1_lit);
        check_bit("cfg ack", 1'b0, cfg_ack);
        mon_on = 1'b1;
        end_test();

        // Timing writes, then one floor of travel and one door cycle.
        begin_test("config");
        cfg_write(elev_pkg::CFG_TRAVEL, 8'd4);
        cfg_write(elev_pkg::CFG_DOOR, 8'd2);
        press_car(0, 2'd1);
        n = 1;
        @(negedge clk);
        while (car0_floor == 2'd0) begin
            n++;
            @(negedge clk);
        end
        // Press cycle, one cycle to start, then four cycles of travel.
        check_count("cycles at floor 0 after call", 1 + 1 + 4, n);
        check_floor("car0 floor after trip", 2'd1, car0_floor);
        while (!car0_door_open) begin
            @(negedge clk);
        end
        n = 0;
        while (car0_door_open) begin
            n++;
            @(negedge clk);
        end
        check_count("door open cycles", 2, n);
        end_test();

        // Car call to the top floor.
        begin_test("car call");
        wait_idle();
        press_car(0, 2'd3);
        @(negedge clk);
        check_mask("car0 lamp lit", 4'b1000, car0_lit);
        wait_served(0, 2'd3);
        check_mask("car0 lamp after arrival", '0, car0_lit);
        end_test();

        // Hall call at floor 0 with car 0 up top and car 1 below it.
        begin_test("hall call");
        wait_idle();
        drive_slot();
        hall_up = 4'b0001;
        drive_slot();
        hall_up = '0;
        @(negedge clk);
        check_mask("up lamp next cycle", 4'b0001, up_lit);
        drive_slot();
        hall_up = 4'b0001;
        drive_slot();
        hall_up = '0;
        @(negedge clk);
        check_mask("up lamp after repeat press", 4'b0001, up_lit);
        while (up_lit[0]) begin
            @(negedge clk);
        end
        while (!((car0_floor == 2'd0 && car0_door_open)
                 || (car1_floor == 2'd0 && car1_door_open))) begin
            @(negedge clk);
        end
        check_mask("up lamp after service", '0, up_lit);
        end_test();

        // Car 1 to the top and back to the ground floor.
        begin_test("reversal");
        wait_idle();
        press_car(1, 2'd3);
        wait_served(1, 2'd3);
        wait_idle();
        press_car(1, 2'd0);
        wait_served(1, 2'd0);
        check_mask("car1 lamp after return", '0, car1_lit);
        end_test();

        // Sparse random calls and then a quiet period.
        begin_test("stress");
        wait_idle();
        repeat (300) begin
            drive_slot();
            rnd       = lcg_next(rnd);
            hall_up   = (rnd[31:28] == 4'd0) ? onehot(rnd[27:26]) : '0;
            hall_down = (rnd[25:22] == 4'd0) ? onehot(rnd[21:20]) : '0;
            car0_call = (rnd[19:16] == 4'd0) ? onehot(rnd[15:14]) : '0;
            car1_call = (rnd[13:10] == 4'd0) ? onehot(rnd[9:8]) : '0;
        end
        drive_slot();
        hall_up   = '0;
        hall_down = '0;
        car0_call = '0;
        car1_call = '0;
        n = 0;
        @(negedge clk);
        while ((up_lit | down_lit | car0_lit | car1_lit) != '0 && n < 4000) begin
            n++;
            @(negedge clk);
        end
        if (n >= 4000) begin
            errors++;
            $display("%s: calls were still lit at the end of the quiet period", cur_test);
        end
        end_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/elevator_bank.sv
// Two-car elevator bank: timing configuration, hall dispatcher and two cars.
// Both cars start at floor 0, door closed, heading up.
`timescale 1ns/1ns
`default_nettype none

module elevator_bank (
    input  logic                  clk,
    input  logic                  rst_n,
    // Timing configuration port.
    input  logic                  cfg_req,
    input  elev_pkg::cfg_sel_t    cfg_sel,
    input  elev_pkg::cycles_t     cfg_data,
    output logic                  cfg_ack,
    // Hall buttons and lamps.
    input  elev_pkg::floor_mask_t hall_up,
    input  elev_pkg::floor_mask_t hall_down,
    output elev_pkg::floor_mask_t up_lit,
    output elev_pkg::floor_mask_t down_lit,
    // Car buttons and status.
    input  elev_pkg::floor_mask_t car0_call,
    input  elev_pkg::floor_mask_t car1_call,
    output elev_pkg::floor_t      car0_floor,
    output elev_pkg::floor_t      car1_floor,
    output logic                  car0_door_open,
    output logic                  car1_door_open,
    output elev_pkg::floor_mask_t car0_lit,
    output elev_pkg::floor_mask_t car1_lit
);

    elev_pkg::cycles_t travel_cycles;
    elev_pkg::cycles_t door_cycles;

    car_link_if link0 ();
    car_link_if link1 ();

    bank_cfg u_cfg (
        .clk          (clk),
        .rst_n        (rst_n),
        .cfg_req      (cfg_req),
        .cfg_sel      (cfg_sel),
        .cfg_data     (cfg_data),
        .cfg_ack      (cfg_ack),
        .travel_cycles(travel_cycles),
        .door_cycles  (door_cycles)
    );

    hall_dispatch u_dispatch (
        .clk      (clk),
        .rst_n    (rst_n),
        .hall_up  (hall_up),
        .hall_down(hall_down),
        .up_lit   (up_lit),
        .down_lit (down_lit),
        .car0     (link0.dispatch),
        .car1     (link1.dispatch)
    );

    car_ctrl u_car0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .car_call     (car0_call),
        .travel_cycles(travel_cycles),
        .door_cycles  (door_cycles),
        .link         (link0.car),
        .door_open    (car0_door_open),
        .floor_lit    (car0_lit)
    );

    car_ctrl u_car1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .car_call     (car1_call),
        .travel_cycles(travel_cycles),
        .door_cycles  (door_cycles),
        .link         (link1.car),
        .door_open    (car1_door_open),
        .floor_lit    (car1_lit)
    );

    // Floor positions come straight from the links.
    assign car0_floor = link0.floor;
    assign car1_floor = link1.floor;

endmodule

`default_nettype wire

// File: hw/car/car_ctrl.sv
// One car: call buttons, heading, motion and door sequencing.
// Travel and door phase lengths come from the configuration block.
`timescale 1ns/1ns
`default_nettype none
`include "elev_defs.svh"

module car_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  elev_pkg::floor_mask_t car_call,
    input  elev_pkg::cycles_t     travel_cycles,
    input  elev_pkg::cycles_t     door_cycles,
    car_link_if.car               link,
    output logic                  door_open,
    output elev_pkg::floor_mask_t floor_lit
);

    localparam elev_pkg::floor_t top_floor = elev_pkg::floor_t'(`ELEV_FLOORS - 1);

    elev_pkg::floor_mask_t buttons_q;
    elev_pkg::floor_mask_t buttons_d;
    elev_pkg::floor_t      floor_q;
    elev_pkg::floor_t      next_floor;
    elev_pkg::dir_t        dir_q;
    elev_pkg::dir_t        dir_d;
    elev_pkg::motion_t     motion_q;
    elev_pkg::door_t       door_q;
    elev_pkg::cycles_t     travel_cnt_q;
    elev_pkg::cycles_t     door_cnt_q;
    logic                  open_pend_q;
    logic                  arrive_q;
    logic                  can_move;
    logic                  ahead;
    logic                  here;
    logic                  start_move;

    always_comb begin
        next_floor = elev_pkg::step_floor(floor_q, dir_q);
        can_move   = elev_pkg::can_step(floor_q, dir_q);
        ahead      = elev_pkg::calls_ahead(buttons_q, floor_q, dir_q);
        here       = buttons_q[floor_q];
        // Leave only with the door shut and nothing to open for here.
        start_move = (motion_q == elev_pkg::MOT_STOPPED) && (door_q == elev_pkg::DOOR_CLOSED)
                   && !open_pend_q && !here && can_move && (ahead || link.keep_going);
    end

    //**********************************************************
    // Buttons and heading.
    //**********************************************************

    always_comb begin
        buttons_d = buttons_q | car_call;
        // The floor being served clears while the door is not shut.
        if (door_q != elev_pkg::DOOR_CLOSED) begin
            buttons_d[floor_q] = 1'b0;
        end
        // A hall call handed over becomes our own stop, last so it sticks.
        if (link.stop_next && can_move) begin
            buttons_d[next_floor] = 1'b1;
        end

        dir_d = dir_q;
        // Turn around only between trips.
        if (motion_q == elev_pkg::MOT_STOPPED && !ahead && !link.keep_going) begin
            dir_d = (dir_q == elev_pkg::DIR_UP) ? elev_pkg::DIR_DOWN : elev_pkg::DIR_UP;
        end
        if (floor_q == top_floor) begin
            dir_d = elev_pkg::DIR_DOWN;
        end
        if (floor_q == '0) begin
            dir_d = elev_pkg::DIR_UP;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            buttons_q   <= '0;
            dir_q       <= elev_pkg::DIR_UP;
            open_pend_q <= 1'b0;
        end else begin
            buttons_q <= buttons_d;
            dir_q     <= dir_d;
            // Arm the door for the floor we are heading to, or for a call here.
            if (door_q != elev_pkg::DOOR_CLOSED) begin
                open_pend_q <= 1'b0;
            end else if (motion_q == elev_pkg::MOT_MOVING && can_move
                         && (link.stop_next || buttons_q[next_floor])) begin
                open_pend_q <= 1'b1;
            end else if (motion_q == elev_pkg::MOT_STOPPED && here) begin
                open_pend_q <= 1'b1;
            end
        end
    end

    //**********************************************************
    // Motion FSM.
    //**********************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            motion_q     <= elev_pkg::MOT_STOPPED;
            floor_q      <= '0;
            travel_cnt_q <= '0;
            arrive_q     <= 1'b0;
        end else begin
            arrive_q <= 1'b0;
            case (motion_q)
                elev_pkg::MOT_STOPPED: begin
                    if (start_move) begin
                        motion_q     <= elev_pkg::MOT_MOVING;
                        travel_cnt_q <= elev_pkg::count_load(travel_cycles);
                    end
                end
                default: begin
                    if (travel_cnt_q == '0) begin
                        motion_q <= elev_pkg::MOT_STOPPED;
                        floor_q  <= next_floor;
                        arrive_q <= 1'b1;
                    end else begin
                        travel_cnt_q <= travel_cnt_q - 1'b1;
                    end
                end
            endcase
        end
    end

    //**********************************************************
    // Door FSM.
    //**********************************************************

    // Each phase after CLOSED lasts door_cycles cycles.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            door_q     <= elev_pkg::DOOR_CLOSED;
            door_cnt_q <= '0;
        end else if (door_q == elev_pkg::DOOR_CLOSED) begin
            if (open_pend_q && motion_q == elev_pkg::MOT_STOPPED) begin
                door_q     <= elev_pkg::DOOR_OPENING;
                door_cnt_q <= elev_pkg::count_load(door_cycles);
            end
        end else if (door_cnt_q != '0) begin
            door_cnt_q <= door_cnt_q - 1'b1;
        end else begin
            door_cnt_q <= elev_pkg::count_load(door_cycles);
            case (door_q)
                elev_pkg::DOOR_OPENING: door_q <= elev_pkg::DOOR_OPEN;
                elev_pkg::DOOR_OPEN:    door_q <= elev_pkg::DOOR_CLOSING;
                default:                door_q <= elev_pkg::DOOR_CLOSED;
            endcase
        end
    end

    // Outputs.
    assign door_open   = (door_q == elev_pkg::DOOR_OPEN);
    assign floor_lit   = buttons_q;
    assign link.floor  = floor_q;
    assign link.dir    = dir_q;
    assign link.arrive = arrive_q;

endmodule

`default_nettype wire

// File: hw/hall_dispatch/hall_dispatch.sv
// Hall call registers and stop scheduling for two cars.
// A call is handed to one car and cleared in the same cycle; car 0 wins ties.
`timescale 1ns/1ns
`default_nettype none

module hall_dispatch (
    input  logic                  clk,
    input  logic                  rst_n,
    input  elev_pkg::floor_mask_t hall_up,
    input  elev_pkg::floor_mask_t hall_down,
    output elev_pkg::floor_mask_t up_lit,
    output elev_pkg::floor_mask_t down_lit,
    car_link_if.dispatch          car0,
    car_link_if.dispatch          car1
);

    elev_pkg::floor_mask_t up_q;
    elev_pkg::floor_mask_t down_q;
    elev_pkg::floor_mask_t pending;
    elev_pkg::floor_mask_t clr;
    elev_pkg::floor_t      next0;
    elev_pkg::floor_t      next1;
    logic                  want0;
    logic                  want1;
    logic                  grant1;

    //**********************************************************
    // Scheduling.
    //**********************************************************

    always_comb begin
        // Either hall button at a floor is a reason to stop there.
        pending = up_q | down_q;

        next0 = elev_pkg::step_floor(car0.floor, car0.dir);
        next1 = elev_pkg::step_floor(car1.floor, car1.dir);

        // A car's heading is settled the cycle after it arrives.
        // Hold its stop request back for that one cycle.
        want0 = !car0.arrive && elev_pkg::can_step(car0.floor, car0.dir) && pending[next0];
        want1 = !car1.arrive && elev_pkg::can_step(car1.floor, car1.dir) && pending[next1];

        // Same target floor in one cycle goes to car 0 only.
        grant1 = want1 && !(want0 && (next0 == next1));

        clr = '0;
        if (want0) begin
            clr[next0] = 1'b1;
        end
        if (grant1) begin
            clr[next1] = 1'b1;
        end
    end

    assign car0.stop_next = want0;
    assign car1.stop_next = grant1;

    // Keep going while calls lie beyond the car.
    // A call at the car's own floor also counts.
    // The car steps away and is then scheduled back to it.
    assign car0.keep_going = elev_pkg::calls_ahead(pending, car0.floor, car0.dir)
                           | pending[car0.floor];
    assign car1.keep_going = elev_pkg::calls_ahead(pending, car1.floor, car1.dir)
                           | pending[car1.floor];

    //**********************************************************
    // Hall call registers.
    //**********************************************************

    // Presses set, scheduling clears; the clear wins in the same edge.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            up_q   <= '0;
            down_q <= '0;
        end else begin
            up_q   <= (up_q | hall_up) & ~clr;
            down_q <= (down_q | hall_down) & ~clr;
        end
    end

    // Lamps show the registered calls.
    assign up_lit   = up_q;
    assign down_lit = down_q;

endmodule

`default_nettype wire

// File: hw/bank_cfg.sv
// Travel and door timing registers behind a four-phase req/ack port.
// The host must wait for ack low before raising req again.
`timescale 1ns/1ns
`default_nettype none
`include "elev_defs.svh"

module bank_cfg (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_req,
    input  elev_pkg::cfg_sel_t cfg_sel,
    input  elev_pkg::cycles_t  cfg_data,
    output logic               cfg_ack,
    output elev_pkg::cycles_t  travel_cycles,
    output elev_pkg::cycles_t  door_cycles
);

    typedef enum logic {HS_IDLE, HS_ACK} hs_state_t;

    hs_state_t         state_q;
    elev_pkg::cycles_t travel_q;
    elev_pkg::cycles_t door_q;

    //**********************************************************
    // Handshake FSM.
    //**********************************************************

    // IDLE takes the write on req high, ACK waits for req to drop.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q  <= HS_IDLE;
            travel_q <= elev_pkg::cycles_t'(`ELEV_TRAVEL_RST);
            door_q   <= elev_pkg::cycles_t'(`ELEV_DOOR_RST);
        end else begin
            case (state_q)
                HS_IDLE: begin
                    if (cfg_req) begin
                        state_q <= HS_ACK;
                        if (cfg_sel == elev_pkg::CFG_TRAVEL) begin
                            travel_q <= cfg_data;
                        end else begin
                            door_q <= cfg_data;
                        end
                    end
                end
                default: begin
                    if (!cfg_req) begin
                        state_q <= HS_IDLE;
                    end
                end
            endcase
        end
    end

    assign cfg_ack       = (state_q == HS_ACK);
    assign travel_cycles = travel_q;
    assign door_cycles   = door_q;

endmodule

`default_nettype wire

// File: common/car_link_if.sv
// Link between the hall dispatcher and one car.
// The car reports position and heading, the dispatcher returns scheduling hints.
`timescale 1ns/1ns
`default_nettype none

interface car_link_if;

    // Car side.
    elev_pkg::floor_t floor;
    elev_pkg::dir_t   dir;
    logic             arrive;

    // Dispatcher side.
    logic             stop_next;
    logic             keep_going;

    modport dispatch (
        input  floor, dir, arrive,
        output stop_next, keep_going
    );

    modport car (
        output floor, dir, arrive,
        input  stop_next, keep_going
    );

endinterface

`default_nettype wire

// File: common/elev_pkg.sv
// Types and small helpers shared by the elevator RTL and its testbench.
// A timing count of 0 behaves as a count of 1.
`default_nettype none
`include "elev_defs.svh"

package elev_pkg;

    typedef logic [`ELEV_FLOOR_W-1:0] floor_t;
    typedef logic [`ELEV_FLOORS-1:0]  floor_mask_t;
    typedef logic [7:0]               cycles_t;

    typedef enum logic {DIR_UP, DIR_DOWN} dir_t;
    typedef enum logic {MOT_STOPPED, MOT_MOVING} motion_t;
    typedef enum logic [1:0] {DOOR_CLOSED, DOOR_OPENING, DOOR_OPEN, DOOR_CLOSING} door_t;
    typedef enum logic {CFG_TRAVEL = 1'b0, CFG_DOOR = 1'b1} cfg_sel_t;

    // True when a floor exists one step ahead in the given direction.
    function automatic logic can_step(floor_t fl, dir_t d);
        return (d == DIR_UP) ? (fl != floor_t'(`ELEV_FLOORS - 1)) : (fl != '0);
    endfunction

    // The floor one step ahead. Only meaningful when can_step holds.
    function automatic floor_t step_floor(floor_t fl, dir_t d);
        return (d == DIR_UP) ? floor_t'(fl + 1'b1) : floor_t'(fl - 1'b1);
    endfunction

    // OR of all calls strictly beyond fl in direction d.
    function automatic logic calls_ahead(floor_mask_t mask, floor_t fl, dir_t d);
        logic any;
        any = 1'b0;
        for (int i = 0; i < `ELEV_FLOORS; i++) begin
            if ((d == DIR_UP && i > int'(fl)) || (d == DIR_DOWN && i < int'(fl))) begin
                any = any | mask[i];
            end
        end
        return any;
    endfunction

    // Down-counter load for a phase of c cycles.
    function automatic cycles_t count_load(cycles_t c);
        return (c == '0) ? '0 : cycles_t'(c - 1'b1);
    endfunction

endpackage

`default_nettype wire

// File: common/elev_defs.svh
// Bank geometry and reset timing for the two-car elevator design.
// ELEV_FLOOR_W must be wide enough to number ELEV_FLOORS floors.
`ifndef ELEV_DEFS_SVH
`define ELEV_DEFS_SVH

// Number of floors served, numbered from 0.
`define ELEV_FLOORS 4

// Bits needed to hold one floor number.
`define ELEV_FLOOR_W 2

// Reset values of the travel count and the door phase count, in cycles.
`define ELEV_TRAVEL_RST 6
`define ELEV_DOOR_RST 3

`endif
